// ==== Bender.yml ====
package:
  name: control_unit

sources:
  - hdl/cu_pkg.sv
  - hdl/cu_event_if.sv
  - hdl/cu_event_tracker.sv
  - hdl/cu_fetch_redirect.sv
  - hdl/cu_hazard_ctrl.sv
  - hdl/cu_rename_commit_ctrl.sv
  - hdl/control_unit.sv
  - target: simulation
    files:
      - verif/tb_control_unit.sv

// ==== build.f ====
hdl/cu_pkg.sv
hdl/cu_event_if.sv
hdl/cu_event_tracker.sv
hdl/cu_fetch_redirect.sv
hdl/cu_hazard_ctrl.sv
hdl/cu_rename_commit_ctrl.sv
hdl/control_unit.sv
verif/tb_control_unit.sv

// ==== hdl/control_unit.sv ====
`timescale 1ns/1ps

module control_unit #(
    parameter int NUM_WB = cu_pkg::DEF_NUM_WB,
    parameter int RETIRE_W = cu_pkg::DEF_RETIRE_W,
    parameter int GL_INDEX_W = cu_pkg::DEF_GL_INDEX_W,
    parameter int CHKP_W = cu_pkg::DEF_CHKP_W
) (
    input  logic             clk_i,
    input  logic             rstn_i,
    input  logic             miss_icache_i,
    input  logic             ready_icache_i,
    input  logic             id_valid_i,
    input  logic             id_is_branch_i,
    input  logic             id_predicted_as_branch_i,
    input  logic             id_valid_jal_i,
    input  logic             id_stall_csr_fence_i,
    input  logic             ir_valid_i,
    input  logic             ir_is_branch_i,
    input  logic             ir_empty_free_list_i,
    input  logic             ir_out_of_checkpoints_i,
    input  logic             ir_full_iq_i,
    input  logic             rr_gl_full_i,
    input  logic             exe_stall_i,
    input  logic [NUM_WB-1:0] wb_valid_i,
    input  logic [NUM_WB-1:0] wb_write_enable_i,
    input  logic             wb_correct_pred_i,
    input  logic             wb_checkpoint_done_i,
    input  logic [CHKP_W-1:0] wb_chkp_i,
    input  logic [GL_INDEX_W-1:0] wb_gl_index_i,
    input  logic             commit_valid_i,
    input  logic             commit_xcpt_i,
    input  logic             commit_ecall_i,
    input  logic             commit_fence_i,
    input  logic             commit_fencei_i,
    input  logic             commit_stall_csr_fence_i,
    input  logic             commit_write_enable_i,
    input  logic [RETIRE_W-1:0] commit_retire_i,
    input  logic [RETIRE_W-1:0] commit_regfile_we_i,
    input  logic             commit_stall_commit_i,
    input  logic             csr_eret_i,
    input  logic             csr_exception_i,
    input  logic             csr_stall_i,
    output cu_pkg::next_pc_sel_e next_pc_sel_o,
    output cu_pkg::sel_addr_e sel_addr_if_o,
    output logic             invalidate_icache_o,
    output logic             invalidate_buffer_o,
    output logic             stall_if1_o,
    output logic             stall_if2_o,
    output logic             stall_id_o,
    output logic             stall_iq_o,
    output logic             stall_ir_o,
    output logic             stall_rr_o,
    output logic             stall_exe_o,
    output logic             flush_if_o,
    output logic             flush_id_o,
    output logic             flush_ir_o,
    output logic             flush_rr_o,
    output logic             flush_exe_o,
    output logic             kill_exe_o,
    output logic             do_checkpoint_o,
    output logic             do_recover_o,
    output logic             delete_checkpoint_o,
    output logic [CHKP_W-1:0] recover_chkp_o,
    output logic [RETIRE_W-1:0] commit_update_o,
    output logic             commit_flush_o,
    output logic             enable_commit_o,
    output logic             flush_gl_o,
    output logic [GL_INDEX_W-1:0] flush_gl_index_o,
    output logic [NUM_WB-1:0] rf_write_enable_o,
    output logic             jump_mispred_o
);
    cu_event_if ev_bus (
        .clk_i  (clk_i),
        .rstn_i (rstn_i)
    );

    cu_event_tracker i_event_tracker (
        .wb_valid0_i (wb_valid_i[0]),
        .ev_o        (ev_bus),
        .*
    );

    // fetch sees the hazard unit's if1 stall
    cu_fetch_redirect i_fetch_redirect (
        .ev_i        (ev_bus),
        .stall_if1_i (stall_if1_o),
        .*
    );

    cu_hazard_ctrl i_hazard_ctrl (
        .ev_i (ev_bus),
        .*
    );

    cu_rename_commit_ctrl #(
        .NUM_WB     (NUM_WB),
        .RETIRE_W   (RETIRE_W),
        .GL_INDEX_W (GL_INDEX_W),
        .CHKP_W     (CHKP_W)
    ) i_rename_commit_ctrl (
        .ev_i       (ev_bus),
        .flush_ir_i (flush_ir_o),
        .stall_ir_i (stall_ir_o),
        .*
    );

endmodule

// ==== hdl/cu_event_if.sv ====
`timescale 1ns/1ps

interface cu_event_if (
    input logic clk_i,
    input logic rstn_i
);
    cu_pkg::redirect_state_e state;
    logic exception_next;
    logic fence_pending;
    logic wb_mispredict;
    logic id_bad_prediction;
    logic jump_request;

    modport tracker (
        output state, exception_next, fence_pending,
        output wb_mispredict, id_bad_prediction, jump_request
    );

    // clock and reset are visible so consumers can clock their checks
    modport consumer (
        input clk_i, rstn_i,
        input state, exception_next, fence_pending,
        input wb_mispredict, id_bad_prediction, jump_request
    );
endinterface

// ==== hdl/cu_event_tracker.sv ====
`timescale 1ns/1ps

module cu_event_tracker (
    input  logic        clk_i,
    input  logic        rstn_i,
    input  logic        id_valid_i,
    input  logic        id_is_branch_i,
    input  logic        id_predicted_as_branch_i,
    input  logic        id_valid_jal_i,
    input  logic        id_stall_csr_fence_i,
    input  logic        wb_valid0_i,
    input  logic        wb_correct_pred_i,
    input  logic        commit_valid_i,
    input  logic        commit_xcpt_i,
    input  logic        commit_ecall_i,
    input  logic        commit_stall_csr_fence_i,
    input  logic        csr_eret_i,
    input  logic        csr_exception_i,
    cu_event_if.tracker ev_o
);
    cu_pkg::redirect_state_e state_q;
    cu_pkg::redirect_state_e state_d;
    logic xcpt_event;
    logic csr_event;
    logic exception_next;
    logic csr_next;
    logic fence_pending_q;
    logic wb_mispredict;
    logic id_bad_prediction;

    assign xcpt_event = (commit_valid_i && (commit_xcpt_i || commit_ecall_i)) ||
                        csr_eret_i || csr_exception_i;
    assign csr_event = commit_valid_i && commit_stall_csr_fence_i;

    // a state cannot be re-entered during its own cycle
    assign exception_next = xcpt_event && (state_q != cu_pkg::RS_XCPT);
    assign csr_next = csr_event && !xcpt_event && (state_q != cu_pkg::RS_CSR);

    always_comb begin
        if (exception_next) begin
            state_d = cu_pkg::RS_XCPT;
        end else if (csr_next) begin
            state_d = cu_pkg::RS_CSR;
        end else begin
            state_d = cu_pkg::RS_IDLE;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= cu_pkg::RS_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // csr/fence seen at decode but not yet committed
    // an exception redirect or a mispredict drops it first
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            fence_pending_q <= 1'b0;
        end else if (state_q == cu_pkg::RS_XCPT || wb_mispredict) begin
            fence_pending_q <= 1'b0;
        end else if (id_valid_i && id_stall_csr_fence_i) begin
            fence_pending_q <= 1'b1;
        end else if (csr_event) begin
            fence_pending_q <= 1'b0;
        end
    end

    assign wb_mispredict = wb_valid0_i && !wb_correct_pred_i;
    assign id_bad_prediction = id_valid_i && !id_is_branch_i && id_predicted_as_branch_i;

    assign ev_o.state = state_q;
    assign ev_o.exception_next = exception_next;
    assign ev_o.fence_pending = fence_pending_q;
    assign ev_o.wb_mispredict = wb_mispredict;
    assign ev_o.id_bad_prediction = id_bad_prediction;
    assign ev_o.jump_request = wb_mispredict || id_bad_prediction || id_valid_jal_i;

    a_xcpt_one_cycle: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        state_q == cu_pkg::RS_XCPT |=> state_q != cu_pkg::RS_XCPT
    );

endmodule

// ==== hdl/cu_fetch_redirect.sv ====
`timescale 1ns/1ps

module cu_fetch_redirect (
    cu_event_if.consumer      ev_i,
    input  logic              stall_if1_i,
    input  logic              id_valid_i,
    input  logic              id_stall_csr_fence_i,
    input  logic              commit_valid_i,
    input  logic              commit_fence_i,
    input  logic              commit_fencei_i,
    input  logic              commit_stall_csr_fence_i,
    output cu_pkg::next_pc_sel_e next_pc_sel_o,
    output cu_pkg::sel_addr_e sel_addr_if_o,
    output logic              invalidate_icache_o,
    output logic              invalidate_buffer_o
);
    logic keep_pc;

    // hold fetch while a csr/fence is in flight or fetch is stalled
    assign keep_pc = stall_if1_i || (id_valid_i && id_stall_csr_fence_i) ||
                     ev_i.fence_pending || (commit_valid_i && commit_fence_i);

    always_comb begin
        if (ev_i.jump_request || ev_i.state != cu_pkg::RS_IDLE) begin
            next_pc_sel_o = cu_pkg::NEXT_PC_JUMP;
        end else if (keep_pc) begin
            next_pc_sel_o = cu_pkg::NEXT_PC_KEEP;
        end else begin
            next_pc_sel_o = cu_pkg::NEXT_PC_BP_OR_PC_4;
        end
    end

    // csr redirects win over a branch redirect from writeback
    always_comb begin
        if (ev_i.state == cu_pkg::RS_XCPT) begin
            sel_addr_if_o = cu_pkg::SEL_JUMP_CSR;
        end else if (ev_i.state == cu_pkg::RS_CSR) begin
            sel_addr_if_o = cu_pkg::SEL_JUMP_CSR_RW;
        end else if (ev_i.wb_mispredict) begin
            sel_addr_if_o = cu_pkg::SEL_JUMP_EXECUTION;
        end else begin
            sel_addr_if_o = cu_pkg::SEL_JUMP_DECODE;
        end
    end

    // fence.i may follow self-modifying code
    assign invalidate_icache_o = commit_valid_i && commit_fencei_i;

    // refetch after fence.i, exceptions and csr writes
    assign invalidate_buffer_o = commit_valid_i &&
                                 (commit_fencei_i || ev_i.state == cu_pkg::RS_XCPT ||
                                  (commit_stall_csr_fence_i && !commit_fence_i));

endmodule

// ==== hdl/cu_hazard_ctrl.sv ====
`timescale 1ns/1ps

module cu_hazard_ctrl (
    cu_event_if.consumer ev_i,
    input  logic         miss_icache_i,
    input  logic         ready_icache_i,
    input  logic         id_stall_csr_fence_i,
    input  logic         id_valid_jal_i,
    input  logic         ir_empty_free_list_i,
    input  logic         ir_out_of_checkpoints_i,
    input  logic         ir_full_iq_i,
    input  logic         rr_gl_full_i,
    input  logic         exe_stall_i,
    input  logic         commit_valid_i,
    input  logic         commit_fence_i,
    input  logic         commit_stall_csr_fence_i,
    input  logic         csr_stall_i,
    output logic         stall_if1_o,
    output logic         stall_if2_o,
    output logic         stall_id_o,
    output logic         stall_iq_o,
    output logic         stall_ir_o,
    output logic         stall_rr_o,
    output logic         stall_exe_o,
    output logic         flush_if_o,
    output logic         flush_id_o,
    output logic         flush_ir_o,
    output logic         flush_rr_o,
    output logic         flush_exe_o,
    output logic         kill_exe_o
);
    logic front_redirect;
    logic if_bubble;
    logic front_full_stall;

    // full front-end flush on any redirect
    assign front_redirect = (ev_i.state != cu_pkg::RS_IDLE) || ev_i.wb_mispredict;

    // drop only the fetched instruction, decode keeps its own
    assign if_bubble = id_stall_csr_fence_i || ev_i.fence_pending ||
                       commit_stall_csr_fence_i || id_valid_jal_i ||
                       (commit_valid_i && commit_fence_i) || ev_i.id_bad_prediction;

    assign flush_id_o = front_redirect;
    assign flush_if_o = front_redirect || (!csr_stall_i && if_bubble);

    always_comb begin
        flush_ir_o = 1'b0;
        flush_rr_o = 1'b0;
        flush_exe_o = 1'b0;
        kill_exe_o = 1'b0;
        if (ev_i.state == cu_pkg::RS_XCPT) begin
            flush_ir_o = 1'b1;
            flush_rr_o = 1'b1;
            flush_exe_o = 1'b1;
        end else if (ev_i.wb_mispredict) begin
            flush_ir_o = 1'b1;
            flush_rr_o = 1'b1;
            kill_exe_o = 1'b1;
        end else if (rr_gl_full_i && !exe_stall_i) begin
            // bubble into rr while the graduation list drains
            flush_rr_o = 1'b1;
        end
    end

    assign front_full_stall = csr_stall_i || ir_full_iq_i;
    assign stall_if2_o = front_full_stall;
    assign stall_id_o = front_full_stall;
    assign stall_if1_o = front_full_stall || (commit_valid_i && commit_stall_csr_fence_i) ||
                         miss_icache_i || !ready_icache_i;

    always_comb begin
        stall_iq_o = 1'b0;
        stall_ir_o = 1'b0;
        stall_rr_o = 1'b0;
        stall_exe_o = 1'b0;
        if (csr_stall_i) begin
            stall_iq_o = 1'b1;
            stall_ir_o = 1'b1;
            stall_rr_o = 1'b1;
            stall_exe_o = 1'b1;
        end else if (exe_stall_i || rr_gl_full_i) begin
            stall_iq_o = 1'b1;
            stall_ir_o = 1'b1;
            stall_rr_o = 1'b1;
        end else if (ir_empty_free_list_i || ir_out_of_checkpoints_i) begin
            // rename resources exhausted, hold only the issue queue
            stall_iq_o = 1'b1;
        end
    end

    // the registered exception redirect empties front and back end one cycle later
    a_xcpt_flushes_all: assert property (
        @(posedge ev_i.clk_i) disable iff (!ev_i.rstn_i)
        ev_i.exception_next |=> flush_if_o && flush_id_o && flush_ir_o && flush_exe_o
    );

endmodule

// ==== hdl/cu_pkg.sv ====
package cu_pkg;

    // how fetch forms the next pc
    typedef enum logic [1:0] {
        NEXT_PC_BP_OR_PC_4 = 2'b00,
        NEXT_PC_KEEP       = 2'b01,
        NEXT_PC_JUMP       = 2'b10
    } next_pc_sel_e;

    // source of the jump address at fetch
    typedef enum logic [1:0] {
        SEL_JUMP_DECODE    = 2'b00,
        SEL_JUMP_EXECUTION = 2'b01,
        SEL_JUMP_CSR       = 2'b10,
        SEL_JUMP_CSR_RW    = 2'b11
    } sel_addr_e;

    // one-cycle redirect after a committed exception or csr/fence
    typedef enum logic [1:0] {
        RS_IDLE = 2'b00,
        RS_XCPT = 2'b01,
        RS_CSR  = 2'b10
    } redirect_state_e;

    // scalar writeback lanes
    parameter int DEF_NUM_WB = 2;
    // instructions retired per cycle
    parameter int DEF_RETIRE_W = 2;
    parameter int DEF_GL_INDEX_W = 6;
    parameter int DEF_CHKP_W = 2;

endpackage

// ==== hdl/cu_rename_commit_ctrl.sv ====
`timescale 1ns/1ps

module cu_rename_commit_ctrl #(
    parameter int NUM_WB = cu_pkg::DEF_NUM_WB,
    parameter int RETIRE_W = cu_pkg::DEF_RETIRE_W,
    parameter int GL_INDEX_W = cu_pkg::DEF_GL_INDEX_W,
    parameter int CHKP_W = cu_pkg::DEF_CHKP_W
) (
    cu_event_if.consumer     ev_i,
    input  logic             flush_ir_i,
    input  logic             stall_ir_i,
    input  logic             ir_valid_i,
    input  logic             ir_is_branch_i,
    input  logic             ir_out_of_checkpoints_i,
    input  logic [NUM_WB-1:0] wb_valid_i,
    input  logic [NUM_WB-1:0] wb_write_enable_i,
    input  logic             wb_correct_pred_i,
    input  logic             wb_checkpoint_done_i,
    input  logic [CHKP_W-1:0] wb_chkp_i,
    input  logic [GL_INDEX_W-1:0] wb_gl_index_i,
    input  logic             commit_valid_i,
    input  logic             commit_xcpt_i,
    input  logic             commit_write_enable_i,
    input  logic [RETIRE_W-1:0] commit_retire_i,
    input  logic [RETIRE_W-1:0] commit_regfile_we_i,
    input  logic             commit_stall_commit_i,
    input  logic             csr_exception_i,
    output logic             do_checkpoint_o,
    output logic             do_recover_o,
    output logic             delete_checkpoint_o,
    output logic [CHKP_W-1:0] recover_chkp_o,
    output logic [RETIRE_W-1:0] commit_update_o,
    output logic             commit_flush_o,
    output logic             enable_commit_o,
    output logic             flush_gl_o,
    output logic [GL_INDEX_W-1:0] flush_gl_index_o,
    output logic [NUM_WB-1:0] rf_write_enable_o,
    output logic             jump_mispred_o
);
    logic commit_rf_write;

    // snapshot rename state for each branch that actually enters rename
    assign do_checkpoint_o = ir_valid_i && ir_is_branch_i && !ir_out_of_checkpoints_i &&
                             !flush_ir_i && !stall_ir_i;
    assign do_recover_o = ev_i.wb_mispredict && wb_checkpoint_done_i;
    assign delete_checkpoint_o = wb_valid_i[0] && wb_correct_pred_i && wb_checkpoint_done_i;
    assign recover_chkp_o = wb_chkp_i;

    // nothing retires in the cycle that raises the exception redirect
    assign commit_update_o = commit_retire_i & commit_regfile_we_i &
                             {RETIRE_W{!ev_i.exception_next}};
    assign commit_flush_o = (ev_i.state == cu_pkg::RS_XCPT);
    assign enable_commit_o = !commit_stall_commit_i && !ev_i.exception_next;

    assign flush_gl_o = ev_i.wb_mispredict;
    assign flush_gl_index_o = ev_i.wb_mispredict ? wb_gl_index_i : '0;

    // commit shares the lane 0 write port
    assign commit_rf_write = commit_valid_i && !commit_xcpt_i && !csr_exception_i &&
                             commit_write_enable_i;
    assign rf_write_enable_o = (wb_valid_i & wb_write_enable_i) | NUM_WB'(commit_rf_write);

    assign jump_mispred_o = ev_i.id_bad_prediction || ev_i.wb_mispredict;

    a_recover_xor_delete: assert property (
        @(posedge ev_i.clk_i) disable iff (!ev_i.rstn_i)
        !(do_recover_o && delete_checkpoint_o)
    );

endmodule

// ==== verif/tb_control_unit.sv ====
`timescale 1ns/1ps

module tb_control_unit;
    localparam int NUM_WB = cu_pkg::DEF_NUM_WB;
    localparam int RETIRE_W = cu_pkg::DEF_RETIRE_W;
    localparam int GL_INDEX_W = cu_pkg::DEF_GL_INDEX_W;
    localparam int CHKP_W = cu_pkg::DEF_CHKP_W;
    localparam int NUM_CYCLES = 2000;
    // reset plus random cycles, with some margin
    localparam int TIMEOUT_CYCLES = NUM_CYCLES + 100;

    logic clk_i;
    logic rstn_i;
    logic miss_icache_i, ready_icache_i;
    logic id_valid_i, id_is_branch_i, id_predicted_as_branch_i;
    logic id_valid_jal_i, id_stall_csr_fence_i;
    logic ir_valid_i, ir_is_branch_i, ir_empty_free_list_i;
    logic ir_out_of_checkpoints_i, ir_full_iq_i;
    logic rr_gl_full_i, exe_stall_i;
    logic [NUM_WB-1:0] wb_valid_i, wb_write_enable_i;
    logic wb_correct_pred_i, wb_checkpoint_done_i;
    logic [CHKP_W-1:0] wb_chkp_i;
    logic [GL_INDEX_W-1:0] wb_gl_index_i;
    logic commit_valid_i, commit_xcpt_i, commit_ecall_i, commit_fence_i;
    logic commit_fencei_i, commit_stall_csr_fence_i, commit_write_enable_i;
    logic [RETIRE_W-1:0] commit_retire_i, commit_regfile_we_i;
    logic commit_stall_commit_i;
    logic csr_eret_i, csr_exception_i, csr_stall_i;

    cu_pkg::next_pc_sel_e next_pc_sel_o;
    cu_pkg::sel_addr_e sel_addr_if_o;
    logic invalidate_icache_o, invalidate_buffer_o;
    logic stall_if1_o, stall_if2_o, stall_id_o, stall_iq_o;
    logic stall_ir_o, stall_rr_o, stall_exe_o;
    logic flush_if_o, flush_id_o, flush_ir_o, flush_rr_o, flush_exe_o, kill_exe_o;
    logic do_checkpoint_o, do_recover_o, delete_checkpoint_o;
    logic [CHKP_W-1:0] recover_chkp_o;
    logic [RETIRE_W-1:0] commit_update_o;
    logic commit_flush_o, enable_commit_o, flush_gl_o;
    logic [GL_INDEX_W-1:0] flush_gl_index_o;
    logic [NUM_WB-1:0] rf_write_enable_o;
    logic jump_mispred_o;

    // reference model state
    cu_pkg::redirect_state_e m_state, m_state_next;
    logic m_fp, m_fp_next;

    // expected outputs
    cu_pkg::next_pc_sel_e e_next_pc;
    cu_pkg::sel_addr_e e_sel_addr;
    logic e_inv_icache, e_inv_buffer;
    logic e_stall_if1, e_stall_front, e_stall_iq, e_stall_ir, e_stall_rr, e_stall_exe;
    logic e_flush_if, e_flush_id, e_flush_ir, e_flush_rr, e_flush_exe, e_kill_exe;
    logic e_do_chkp, e_do_recover, e_delete_chkp, e_commit_flush, e_enable_commit;
    logic [RETIRE_W-1:0] e_commit_update;
    logic [GL_INDEX_W-1:0] e_gl_index;
    logic [NUM_WB-1:0] e_rf_we;
    logic e_wb_mis, e_jump_mispred;

    logic [31:0] lcg_state;
    int n_errors = 0;
    int n_checks = 0;
    int cycle_count = 0;

    control_unit #(
        .NUM_WB     (NUM_WB),
        .RETIRE_W   (RETIRE_W),
        .GL_INDEX_W (GL_INDEX_W),
        .CHKP_W     (CHKP_W)
    ) i_dut (
        .*
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("run stopped because the cycle limit of %0d was reached", TIMEOUT_CYCLES);
            $display("Finished with errors");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // true with a probability of pct percent
    function automatic logic chance(int pct);
        logic [31:0] r;
        r = next_rand();
        return (r[31:16] % 100) < pct;
    endfunction

    task automatic clear_inputs();
        {miss_icache_i, id_valid_i, id_is_branch_i, id_predicted_as_branch_i} = '0;
        {id_valid_jal_i, id_stall_csr_fence_i, ir_valid_i, ir_is_branch_i} = '0;
        {ir_empty_free_list_i, ir_out_of_checkpoints_i, ir_full_iq_i} = '0;
        {rr_gl_full_i, exe_stall_i, wb_valid_i, wb_write_enable_i} = '0;
        {wb_correct_pred_i, wb_checkpoint_done_i, wb_chkp_i, wb_gl_index_i} = '0;
        {commit_valid_i, commit_xcpt_i, commit_ecall_i, commit_fence_i} = '0;
        {commit_fencei_i, commit_stall_csr_fence_i, commit_write_enable_i} = '0;
        {commit_retire_i, commit_regfile_we_i, commit_stall_commit_i} = '0;
        {csr_eret_i, csr_exception_i, csr_stall_i} = '0;
        ready_icache_i = 1'b1;
    endtask

    task automatic drive_inputs();
        logic [31:0] r;
        r = next_rand();
        wb_valid_i = NUM_WB'(r >> 30);
        wb_write_enable_i = NUM_WB'(r >> 24);
        wb_chkp_i = CHKP_W'(r >> 26);
        wb_gl_index_i = GL_INDEX_W'(r >> 8);
        commit_retire_i = RETIRE_W'(r >> 16);
        commit_regfile_we_i = RETIRE_W'(r >> 20);
        miss_icache_i = chance(10);
        ready_icache_i = chance(90);
        id_valid_i = chance(75);
        id_is_branch_i = chance(20);
        id_predicted_as_branch_i = chance(15);
        id_valid_jal_i = chance(5);
        id_stall_csr_fence_i = chance(5);
        ir_valid_i = chance(75);
        ir_is_branch_i = chance(25);
        ir_empty_free_list_i = chance(10);
        ir_out_of_checkpoints_i = chance(10);
        ir_full_iq_i = chance(10);
        rr_gl_full_i = chance(8);
        exe_stall_i = chance(15);
        wb_correct_pred_i = !chance(15);
        wb_checkpoint_done_i = chance(50);
        commit_valid_i = chance(60);
        commit_xcpt_i = chance(3);
        commit_ecall_i = chance(2);
        commit_fence_i = chance(6);
        commit_fencei_i = chance(4);
        commit_stall_csr_fence_i = chance(6);
        commit_write_enable_i = chance(50);
        commit_stall_commit_i = chance(15);
        csr_eret_i = chance(2);
        csr_exception_i = chance(2);
        csr_stall_i = chance(5);
    endtask

    task automatic compute_expected();
        logic xcpt_ev;
        logic csr_ev;
        logic exc_next;
        logic csr_next;
        logic bad_pred;
        logic redirect;
        logic keep;
        logic if_bubble;
        xcpt_ev = (commit_valid_i && (commit_xcpt_i || commit_ecall_i)) ||
                  csr_eret_i || csr_exception_i;
        csr_ev = commit_valid_i && commit_stall_csr_fence_i;
        exc_next = xcpt_ev && (m_state != cu_pkg::RS_XCPT);
        csr_next = csr_ev && !xcpt_ev && (m_state != cu_pkg::RS_CSR);
        e_wb_mis = wb_valid_i[0] && !wb_correct_pred_i;
        bad_pred = id_valid_i && !id_is_branch_i && id_predicted_as_branch_i;
        redirect = (m_state != cu_pkg::RS_IDLE) || e_wb_mis;

        // front end stalls and flushes
        e_stall_front = csr_stall_i || ir_full_iq_i;
        e_stall_if1 = e_stall_front || csr_ev || miss_icache_i || !ready_icache_i;
        if_bubble = id_stall_csr_fence_i || m_fp || commit_stall_csr_fence_i ||
                    id_valid_jal_i || (commit_valid_i && commit_fence_i) || bad_pred;
        e_flush_id = redirect;
        e_flush_if = redirect || (!csr_stall_i && if_bubble);

        // fetch redirect
        keep = e_stall_if1 || (id_valid_i && id_stall_csr_fence_i) || m_fp ||
               (commit_valid_i && commit_fence_i);
        if (e_wb_mis || bad_pred || id_valid_jal_i || m_state != cu_pkg::RS_IDLE)
            e_next_pc = cu_pkg::NEXT_PC_JUMP;
        else if (keep)
            e_next_pc = cu_pkg::NEXT_PC_KEEP;
        else
            e_next_pc = cu_pkg::NEXT_PC_BP_OR_PC_4;
        if (m_state == cu_pkg::RS_XCPT)
            e_sel_addr = cu_pkg::SEL_JUMP_CSR;
        else if (m_state == cu_pkg::RS_CSR)
            e_sel_addr = cu_pkg::SEL_JUMP_CSR_RW;
        else if (e_wb_mis)
            e_sel_addr = cu_pkg::SEL_JUMP_EXECUTION;
        else
            e_sel_addr = cu_pkg::SEL_JUMP_DECODE;
        e_inv_icache = commit_valid_i && commit_fencei_i;
        e_inv_buffer = commit_valid_i && (commit_fencei_i || m_state == cu_pkg::RS_XCPT ||
                                          (commit_stall_csr_fence_i && !commit_fence_i));

        // back end flushes, highest priority first
        {e_flush_ir, e_flush_rr, e_flush_exe, e_kill_exe} = 4'b0000;
        if (m_state == cu_pkg::RS_XCPT)
            {e_flush_ir, e_flush_rr, e_flush_exe} = 3'b111;
        else if (e_wb_mis)
            {e_flush_ir, e_flush_rr, e_kill_exe} = 3'b111;
        else if (rr_gl_full_i && !exe_stall_i)
            e_flush_rr = 1'b1;

        {e_stall_iq, e_stall_ir, e_stall_rr, e_stall_exe} = 4'b0000;
        if (csr_stall_i)
            {e_stall_iq, e_stall_ir, e_stall_rr, e_stall_exe} = 4'b1111;
        else if (exe_stall_i || rr_gl_full_i)
            {e_stall_iq, e_stall_ir, e_stall_rr} = 3'b111;
        else if (ir_empty_free_list_i || ir_out_of_checkpoints_i)
            e_stall_iq = 1'b1;

        // rename and commit
        e_do_chkp = ir_valid_i && ir_is_branch_i && !ir_out_of_checkpoints_i &&
                    !e_flush_ir && !e_stall_ir;
        e_do_recover = e_wb_mis && wb_checkpoint_done_i;
        e_delete_chkp = wb_valid_i[0] && wb_correct_pred_i && wb_checkpoint_done_i;
        e_commit_update = exc_next ? '0 : (commit_retire_i & commit_regfile_we_i);
        e_commit_flush = (m_state == cu_pkg::RS_XCPT);
        e_enable_commit = !commit_stall_commit_i && !exc_next;
        e_gl_index = e_wb_mis ? wb_gl_index_i : '0;
        e_rf_we = wb_valid_i & wb_write_enable_i;
        if (commit_valid_i && !commit_xcpt_i && !csr_exception_i && commit_write_enable_i)
            e_rf_we[0] = 1'b1;
        e_jump_mispred = bad_pred || e_wb_mis;

        if (exc_next)
            m_state_next = cu_pkg::RS_XCPT;
        else if (csr_next)
            m_state_next = cu_pkg::RS_CSR;
        else
            m_state_next = cu_pkg::RS_IDLE;
        if (m_state == cu_pkg::RS_XCPT || e_wb_mis)
            m_fp_next = 1'b0;
        else if (id_valid_i && id_stall_csr_fence_i)
            m_fp_next = 1'b1;
        else if (csr_ev)
            m_fp_next = 1'b0;
        else
            m_fp_next = m_fp;
    endtask

    task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] exp);
        n_errors++;
        $display("Mismatch %s: got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
    endtask

    task automatic check_outputs();
        n_checks++;
        if (next_pc_sel_o !== e_next_pc)
            report_mismatch("next_pc_sel_o", next_pc_sel_o, e_next_pc);
        if (sel_addr_if_o !== e_sel_addr)
            report_mismatch("sel_addr_if_o", sel_addr_if_o, e_sel_addr);
        if (invalidate_icache_o !== e_inv_icache)
            report_mismatch("invalidate_icache_o", invalidate_icache_o, e_inv_icache);
        if (invalidate_buffer_o !== e_inv_buffer)
            report_mismatch("invalidate_buffer_o", invalidate_buffer_o, e_inv_buffer);
        if (stall_if1_o !== e_stall_if1) report_mismatch("stall_if1_o", stall_if1_o, e_stall_if1);
        if (stall_if2_o !== e_stall_front)
            report_mismatch("stall_if2_o", stall_if2_o, e_stall_front);
        if (stall_id_o !== e_stall_front)
            report_mismatch("stall_id_o", stall_id_o, e_stall_front);
        if (stall_iq_o !== e_stall_iq) report_mismatch("stall_iq_o", stall_iq_o, e_stall_iq);
        if (stall_ir_o !== e_stall_ir) report_mismatch("stall_ir_o", stall_ir_o, e_stall_ir);
        if (stall_rr_o !== e_stall_rr) report_mismatch("stall_rr_o", stall_rr_o, e_stall_rr);
        if (stall_exe_o !== e_stall_exe) report_mismatch("stall_exe_o", stall_exe_o, e_stall_exe);
        if (flush_if_o !== e_flush_if) report_mismatch("flush_if_o", flush_if_o, e_flush_if);
        if (flush_id_o !== e_flush_id) report_mismatch("flush_id_o", flush_id_o, e_flush_id);
        if (flush_ir_o !== e_flush_ir) report_mismatch("flush_ir_o", flush_ir_o, e_flush_ir);
        if (flush_rr_o !== e_flush_rr) report_mismatch("flush_rr_o", flush_rr_o, e_flush_rr);
        if (flush_exe_o !== e_flush_exe) report_mismatch("flush_exe_o", flush_exe_o, e_flush_exe);
        if (kill_exe_o !== e_kill_exe) report_mismatch("kill_exe_o", kill_exe_o, e_kill_exe);
        if (do_checkpoint_o !== e_do_chkp)
            report_mismatch("do_checkpoint_o", do_checkpoint_o, e_do_chkp);
        if (do_recover_o !== e_do_recover)
            report_mismatch("do_recover_o", do_recover_o, e_do_recover);
        if (delete_checkpoint_o !== e_delete_chkp)
            report_mismatch("delete_checkpoint_o", delete_checkpoint_o, e_delete_chkp);
        if (recover_chkp_o !== wb_chkp_i)
            report_mismatch("recover_chkp_o", recover_chkp_o, wb_chkp_i);
        if (commit_update_o !== e_commit_update)
            report_mismatch("commit_update_o", commit_update_o, e_commit_update);
        if (commit_flush_o !== e_commit_flush)
            report_mismatch("commit_flush_o", commit_flush_o, e_commit_flush);
        if (enable_commit_o !== e_enable_commit)
            report_mismatch("enable_commit_o", enable_commit_o, e_enable_commit);
        if (flush_gl_o !== e_wb_mis) report_mismatch("flush_gl_o", flush_gl_o, e_wb_mis);
        if (flush_gl_index_o !== e_gl_index)
            report_mismatch("flush_gl_index_o", flush_gl_index_o, e_gl_index);
        if (rf_write_enable_o !== e_rf_we)
            report_mismatch("rf_write_enable_o", rf_write_enable_o, e_rf_we);
        if (jump_mispred_o !== e_jump_mispred)
            report_mismatch("jump_mispred_o", jump_mispred_o, e_jump_mispred);
    endtask

    initial begin
        lcg_state = 32'd25;
        m_state = cu_pkg::RS_IDLE;
        m_fp = 1'b0;
        rstn_i = 1'b0;
        clear_inputs();
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        rstn_i = 1'b1;
        for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
            drive_inputs();
            // sample just before the rising edge
            #3;
            compute_expected();
            check_outputs();
            @(posedge clk_i);
            m_state = m_state_next;
            m_fp = m_fp_next;
            @(negedge clk_i);
        end
        $display("cycles checked: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
